// File: files.f
+incdir+rtl
rtl/wb_xbar_pkg.sv
rtl/wb_master_port.sv
rtl/wb_rr_arbiter.sv
rtl/wb_slave_mux.sv
rtl/wb_resp_mux.sv
rtl/wb_xbar_3x3.sv
testbench/wb_xbar_checker.sv
testbench/tb_wb_xbar.sv

// File: rtl/wb_master_port.sv
// ##########################################################################
// Wishbone master port tracker
// Decodes the address of a new transfer and holds the selected target
// until the master sees its ack or err
// ##########################################################################
`timescale 1ns/1ns
`include "wb_xbar_defines.svh"

module wb_master_port (
	input logic clk,
	input logic rstn,
	input wb_xbar_pkg::wb_req_t req_i,
	input wb_xbar_pkg::wb_rsp_t rsp_i,
	output wb_xbar_pkg::port_sel_t sel_o
);
	import wb_xbar_pkg::*;

	port_state_e state_q;
	target_id_t dec_tgt;

	// Address decode, anything outside the windows goes to the error responder
	always_comb begin
		if (req_i.adr >= `WB_S0_BASE && req_i.adr <= `WB_S0_LIMIT) begin
			dec_tgt = target_id_t'(0);
		end else if (req_i.adr >= `WB_S1_BASE && req_i.adr <= `WB_S1_LIMIT) begin
			dec_tgt = target_id_t'(1);
		end else if (req_i.adr >= `WB_S2_BASE && req_i.adr <= `WB_S2_LIMIT) begin
			dec_tgt = target_id_t'(2);
		end else begin
			dec_tgt = `WB_DECERR_ID;
		end
	end

	// Transfer tracking
	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q <= PORT_IDLE;
			sel_o <= '0;
		end else begin
			case (state_q)
				PORT_IDLE: begin
					// New strobed request, latch the decoded target
					if (req_i.cyc && req_i.stb) begin
						state_q <= PORT_BUSY;
						sel_o.valid <= 1'b1;
						sel_o.tgt <= dec_tgt;
					end
				end
				PORT_BUSY: begin
					// Own ack or err ends the transfer
					if (rsp_i.ack || rsp_i.err) begin
						state_q <= PORT_IDLE;
						sel_o.valid <= 1'b0;
					end
				end
				default: begin
					state_q <= PORT_IDLE;
					sel_o.valid <= 1'b0;
				end
			endcase
		end
	end

endmodule

// File: rtl/wb_resp_mux.sv
// ##########################################################################
// Crossbar response mux
// Routes a target's response to the master that holds its grant
// ##########################################################################
`timescale 1ns/1ns
`include "wb_xbar_defines.svh"

module wb_resp_mux (
	input wb_xbar_pkg::port_sel_t sel_i [`WB_N_MASTERS],
	input wb_xbar_pkg::grant_t gnt_i [`WB_N_SLAVES+1],
	input wb_xbar_pkg::wb_rsp_t t_rsp_i [`WB_N_SLAVES+1],
	output wb_xbar_pkg::wb_rsp_t m_rsp_o [`WB_N_MASTERS]
);
	import wb_xbar_pkg::*;

	always_comb begin
		target_id_t tgt;
		for (int m = 0; m < `WB_N_MASTERS; m++) begin
			tgt = sel_i[m].tgt;
			// Default keeps a waiting master quiet
			m_rsp_o[m] = '0;
			// Only the owner of the selected target sees its response
			if (sel_i[m].valid && gnt_i[tgt].valid && gnt_i[tgt].id == master_id_t'(m)) begin
				m_rsp_o[m] = t_rsp_i[tgt];
			end
		end
	end

endmodule

// File: rtl/wb_rr_arbiter.sv
// ##########################################################################
// Round-robin arbiter for one crossbar target
// Picks the next requester after the last winner and keeps the grant
// until that master drops its request
// ##########################################################################
`timescale 1ns/1ns
`include "wb_xbar_defines.svh"

module wb_rr_arbiter (
	input logic clk,
	input logic rstn,
	input logic [`WB_N_MASTERS-1:0] req_i,
	output wb_xbar_pkg::grant_t gnt_o
);
	import wb_xbar_pkg::*;

	arb_state_e state_q;
	// Last granted master, start point of the next search
	master_id_t last_q;

	logic found_above;
	master_id_t pick_above;
	logic found_low;
	master_id_t pick_low;
	master_id_t pick;

	// Search from the top down so the lowest hit is kept
	always_comb begin
		found_above = 1'b0;
		pick_above = '0;
		found_low = 1'b0;
		pick_low = '0;
		for (int i = `WB_N_MASTERS - 1; i >= 0; i--) begin
			if (req_i[i]) begin
				// Lowest requester overall, used on wrap
				found_low = 1'b1;
				pick_low = master_id_t'(i);
				// Lowest requester above the last winner
				if (i > int'(last_q)) begin
					found_above = 1'b1;
					pick_above = master_id_t'(i);
				end
			end
		end
	end

	assign pick = found_above ? pick_above : pick_low;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q <= ARB_IDLE;
			// Master 0 wins the first search
			last_q <= master_id_t'(`WB_N_MASTERS - 1);
			gnt_o <= '0;
		end else begin
			case (state_q)
				ARB_IDLE: begin
					if (found_low) begin
						state_q <= ARB_HOLD;
						gnt_o.valid <= 1'b1;
						gnt_o.id <= pick;
						last_q <= pick;
					end
				end
				ARB_HOLD: begin
					// Release once the owner's request bit falls
					if (!req_i[gnt_o.id]) begin
						state_q <= ARB_IDLE;
						gnt_o.valid <= 1'b0;
					end
				end
				default: begin
					state_q <= ARB_IDLE;
					gnt_o.valid <= 1'b0;
				end
			endcase
		end
	end

endmodule

// File: rtl/wb_slave_mux.sv
// ##########################################################################
// Crossbar request mux and decode-error responder
// Each target sees only the request of its granted master
// ##########################################################################
`timescale 1ns/1ns
`include "wb_xbar_defines.svh"

module wb_slave_mux (
	input logic clk,
	input logic rstn,
	input wb_xbar_pkg::wb_req_t m_req_i [`WB_N_MASTERS],
	input wb_xbar_pkg::grant_t gnt_i [`WB_N_SLAVES+1],
	input wb_xbar_pkg::wb_rsp_t s_rsp_i [`WB_N_SLAVES],
	output wb_xbar_pkg::wb_req_t s_req_o [`WB_N_SLAVES],
	output wb_xbar_pkg::wb_rsp_t t_rsp_o [`WB_N_SLAVES+1]
);
	import wb_xbar_pkg::*;

	// Forwarded request per target, slot 3 stays internal
	wb_req_t fwd [`WB_N_SLAVES+1];
	logic err_q;

	// Granted master's request, all zero without a grant
	always_comb begin
		for (int t = 0; t < `WB_N_SLAVES + 1; t++) begin
			if (gnt_i[t].valid) begin
				fwd[t] = m_req_i[gnt_i[t].id];
			end else begin
				fwd[t] = '0;
			end
		end
	end

	// Real slaves get their forwarded requests
	always_comb begin
		for (int k = 0; k < `WB_N_SLAVES; k++) begin
			s_req_o[k] = fwd[k];
		end
	end

	// Decode-error responder
	// One err pulse per strobe, err_q blocks a second pulse while stb is held
	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			err_q <= fwd[`WB_DECERR_ID].cyc && fwd[`WB_DECERR_ID].stb && !err_q;
		end
	end

	// Target responses, slaves pass straight through
	always_comb begin
		for (int k = 0; k < `WB_N_SLAVES; k++) begin
			t_rsp_o[k] = s_rsp_i[k];
		end
		// Responder never acks and reads back zero
		t_rsp_o[`WB_DECERR_ID].dat_r = '0;
		t_rsp_o[`WB_DECERR_ID].ack = 1'b0;
		t_rsp_o[`WB_DECERR_ID].err = err_q;
	end

endmodule

// File: rtl/wb_xbar_3x3.sv
// ##########################################################################
// Wishbone 3x3 crossbar
// Three masters reach three slaves through per-target round-robin
// arbiters; unmapped addresses end at a decode-error responder
// ##########################################################################
`timescale 1ns/1ns
`include "wb_xbar_defines.svh"

module wb_xbar_3x3 (
	input logic clk,
	input logic rstn,
	input wb_xbar_pkg::wb_req_t m_req_i [`WB_N_MASTERS],
	output wb_xbar_pkg::wb_rsp_t m_rsp_o [`WB_N_MASTERS],
	output wb_xbar_pkg::wb_req_t s_req_o [`WB_N_SLAVES],
	input wb_xbar_pkg::wb_rsp_t s_rsp_i [`WB_N_SLAVES]
);
	import wb_xbar_pkg::*;

	// Target selected by each master
	port_sel_t sel [`WB_N_MASTERS];
	// Requesting masters per target, one bit per master
	logic [`WB_N_MASTERS-1:0] tgt_req [`WB_N_SLAVES+1];
	// Owner of each target
	grant_t gnt [`WB_N_SLAVES+1];
	// Responses of all four targets
	wb_rsp_t t_rsp [`WB_N_SLAVES+1];

	// Per-master transfer tracking
	for (genvar m = 0; m < `WB_N_MASTERS; m++) begin : g_port
		wb_master_port port_i (
			.clk(clk),
			.rstn(rstn),
			.req_i(m_req_i[m]),
			.rsp_i(m_rsp_o[m]),
			.sel_o(sel[m])
		);
	end

	// Request vectors
	// Bit m set while master m has a valid selection of target t
	for (genvar t = 0; t < `WB_N_SLAVES + 1; t++) begin : g_req
		for (genvar m = 0; m < `WB_N_MASTERS; m++) begin : g_bit
			assign tgt_req[t][m] = sel[m].valid && (sel[m].tgt == target_id_t'(t));
		end
	end

	// One arbiter per target, including the error responder
	for (genvar t = 0; t < `WB_N_SLAVES + 1; t++) begin : g_arb
		wb_rr_arbiter arb_i (
			.clk(clk),
			.rstn(rstn),
			.req_i(tgt_req[t]),
			.gnt_o(gnt[t])
		);
	end

	// Master to slave path
	wb_slave_mux slave_mux_i (
		.clk(clk),
		.rstn(rstn),
		.m_req_i(m_req_i),
		.gnt_i(gnt),
		.s_rsp_i(s_rsp_i),
		.s_req_o(s_req_o),
		.t_rsp_o(t_rsp)
	);

	// Slave to master path
	wb_resp_mux resp_mux_i (
		.sel_i(sel),
		.gnt_i(gnt),
		.t_rsp_i(t_rsp),
		.m_rsp_o(m_rsp_o)
	);

endmodule

// File: rtl/wb_xbar_defines.svh
// ##########################################################################
// Wishbone 3x3 crossbar parameters
// Bus widths, port counts and the address windows of the three slaves
// ##########################################################################
`ifndef WB_XBAR_DEFINES_SVH
`define WB_XBAR_DEFINES_SVH

// Bus widths
`define WB_ADDR_WIDTH 32
`define WB_DATA_WIDTH 32

// Port counts, the decode-error responder is one extra target
`define WB_N_MASTERS 3
`define WB_N_SLAVES 3
`define WB_DECERR_ID 2'd3

// Slave windows, limits are inclusive
`define WB_S0_BASE 32'h0000_0000
`define WB_S0_LIMIT 32'h0000_0FFF
`define WB_S1_BASE 32'h0000_1000
`define WB_S1_LIMIT 32'h0000_1FFF
`define WB_S2_BASE 32'h0001_0000
`define WB_S2_LIMIT 32'h0001_FFFF

`endif

// File: rtl/wb_xbar_pkg.sv
// ##########################################################################
// Wishbone 3x3 crossbar types
// Request and response bundles, routing selections, grants and FSM states
// ##########################################################################
`include "wb_xbar_defines.svh"

package wb_xbar_pkg;

	// One master's classic single-transfer request
	typedef struct packed {
		logic [`WB_ADDR_WIDTH-1:0] adr;
		logic [`WB_DATA_WIDTH-1:0] dat_w;
		logic [`WB_DATA_WIDTH/8-1:0] sel;
		logic we;
		logic cyc;
		logic stb;
	} wb_req_t;

	// Response travelling back towards a master
	typedef struct packed {
		logic [`WB_DATA_WIDTH-1:0] dat_r;
		logic ack;
		logic err;
	} wb_rsp_t;

	// Target 0 to 2 are slaves, 3 is the decode-error responder
	typedef logic [1:0] target_id_t;
	typedef logic [1:0] master_id_t;

	// Target a master is currently addressing
	typedef struct packed {
		logic valid;
		target_id_t tgt;
	} port_sel_t;

	// Current owner of one target
	typedef struct packed {
		logic valid;
		master_id_t id;
	} grant_t;

	typedef enum logic {
		PORT_IDLE = 1'b0,
		PORT_BUSY = 1'b1
	} port_state_e;

	typedef enum logic {
		ARB_IDLE = 1'b0,
		ARB_HOLD = 1'b1
	} arb_state_e;

endpackage

// File: testbench/tb_wb_xbar.sv
// ##########################################################################
// Testbench for the Wishbone 3x3 crossbar
// Table-driven masters, three memory slaves with random ack delay
// ##########################################################################
`timescale 1ns/1ns
`include "wb_xbar_defines.svh"

module tb_wb_xbar;
	import wb_xbar_pkg::*;

	localparam int N_ENT = 40;
	localparam int WAIT_LIMIT = 50;

	logic clk;
	logic rstn;
	wb_req_t m_req [`WB_N_MASTERS];
	wb_rsp_t m_rsp [`WB_N_MASTERS];
	wb_req_t s_req [`WB_N_SLAVES];
	wb_rsp_t s_rsp [`WB_N_SLAVES];

	// Expected outcome of each master's current transfer
	logic [`WB_N_MASTERS-1:0] exp_err;
	logic [`WB_N_MASTERS-1:0] exp_we;
	logic [`WB_DATA_WIDTH-1:0] exp_dat [`WB_N_MASTERS];
	logic [`WB_DATA_WIDTH/8-1:0] exp_sel [`WB_N_MASTERS];

	int err_cnt;
	int chk_cnt;
	int timeouts;
	int done_cnt;
	int rng_seed;

	// Stimulus table
	// Entries of one group start together
	int n_ent;
	int tab_grp [N_ENT];
	int tab_mst [N_ENT];
	logic tab_we [N_ENT];
	logic [`WB_ADDR_WIDTH-1:0] tab_adr [N_ENT];
	logic [`WB_DATA_WIDTH-1:0] tab_dat [N_ENT];
	logic [`WB_DATA_WIDTH/8-1:0] tab_sel [N_ENT];
	logic tab_err [N_ENT];

	// Extra ack wait per transfer of 0 to 2 cycles
	logic [1:0] delay_tab [256];

	always #50 clk = ~clk;

	wb_xbar_3x3 dut_i (
		.clk(clk),
		.rstn(rstn),
		.m_req_i(m_req),
		.m_rsp_o(m_rsp),
		.s_req_o(s_req),
		.s_rsp_i(s_rsp)
	);

	wb_xbar_checker chk_i (
		.clk(clk),
		.rstn(rstn),
		.m_req_i(m_req),
		.m_rsp_i(m_rsp),
		.s_req_i(s_req),
		.exp_err_i(exp_err),
		.exp_we_i(exp_we),
		.exp_dat_i(exp_dat),
		.exp_sel_i(exp_sel),
		.err_cnt_o(err_cnt),
		.chk_cnt_o(chk_cnt)
	);

	// Memory slaves of 64 words each
	for (genvar k = 0; k < `WB_N_SLAVES; k++) begin : g_slave
		logic [`WB_DATA_WIDTH-1:0] mem [64];
		logic busy;
		logic [1:0] left;
		logic [5:0] n;

		initial begin
			s_rsp[k] = '0;
			// Fill pattern carries the slave number and the word index
			for (int i = 0; i < 64; i++) begin
				mem[i] = 32'hE000_0000 | (32'(k) << 16) | 32'(i);
			end
		end

		always @(posedge clk) begin : p_mem
			logic [1:0] wait_now;
			logic [5:0] idx;
			// New transfer draws its delay while a running one counts down
			wait_now = busy ? left : delay_tab[k * 64 + int'(n)];
			idx = s_req[k].adr[7:2];
			if (!rstn) begin
				s_rsp[k] <= '0;
				busy <= 1'b0;
				left <= '0;
				n <= '0;
			end else begin
				s_rsp[k].ack <= 1'b0;
				if (s_rsp[k].ack) begin
					busy <= 1'b0;
				end else if (s_req[k].cyc && s_req[k].stb) begin
					if (!busy) begin
						n <= n + 1'b1;
					end
					busy <= 1'b1;
					if (wait_now == 2'd0) begin
						s_rsp[k].ack <= 1'b1;
						if (s_req[k].we) begin
							for (int b = 0; b < `WB_DATA_WIDTH / 8; b++) begin
								if (s_req[k].sel[b]) begin
									mem[idx][8*b +: 8] <= s_req[k].dat_w[8*b +: 8];
								end
							end
							s_rsp[k].dat_r <= '0;
						end else begin
							s_rsp[k].dat_r <= mem[idx];
						end
					end else begin
						left <= wait_now - 1'b1;
					end
				end
			end
		end
	end

	task automatic add_entry(input int g, input int m, input logic we,
			input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel,
			input logic err);
		tab_grp[n_ent] = g;
		tab_mst[n_ent] = m;
		tab_we[n_ent] = we;
		tab_adr[n_ent] = adr;
		tab_dat[n_ent] = dat;
		tab_sel[n_ent] = sel;
		tab_err[n_ent] = err;
		n_ent++;
	endtask

	// Next entry of master m in group g or -1 when none is left
	function automatic int next_entry(input int g, input int m, input int from);
		for (int i = from; i < n_ent; i++) begin
			if (tab_grp[i] == g && tab_mst[i] == m) begin
				return i;
			end
		end
		return -1;
	endfunction

	// Runs all masters of one group in parallel through their own entries
	task automatic run_group(input int g);
		int pos [`WB_N_MASTERS];
		int wait_cnt [`WB_N_MASTERS];
		logic [`WB_N_MASTERS-1:0] busy;
		logic [`WB_N_MASTERS-1:0] done;
		logic more;
		int cur;
		wb_req_t r;
		busy = '0;
		done = '0;
		more = 1'b1;
		for (int m = 0; m < `WB_N_MASTERS; m++) begin
			pos[m] = 0;
			wait_cnt[m] = 0;
		end
		while (more && timeouts == 0) begin
			@(posedge clk);
			for (int m = 0; m < `WB_N_MASTERS; m++) begin
				if (done[m]) begin
					// Response seen last cycle so the strobe drops for one cycle
					m_req[m] <= '0;
					done[m] = 1'b0;
					busy[m] = 1'b0;
				end else if (!busy[m]) begin
					cur = next_entry(g, m, pos[m]);
					if (cur >= 0) begin
						r = '0;
						r.adr = tab_adr[cur];
						r.dat_w = tab_we[cur] ? tab_dat[cur] : '0;
						r.sel = tab_sel[cur];
						r.we = tab_we[cur];
						r.cyc = 1'b1;
						r.stb = 1'b1;
						m_req[m] <= r;
						exp_err[m] <= tab_err[cur];
						exp_we[m] <= tab_we[cur];
						exp_dat[m] <= tab_dat[cur];
						exp_sel[m] <= tab_sel[cur];
						pos[m] = cur + 1;
						busy[m] = 1'b1;
						wait_cnt[m] = 0;
					end
				end
			end
			@(negedge clk);
			more = 1'b0;
			for (int m = 0; m < `WB_N_MASTERS; m++) begin
				if (busy[m]) begin
					more = 1'b1;
					if (m_rsp[m].ack || m_rsp[m].err) begin
						done[m] = 1'b1;
						done_cnt++;
					end else begin
						wait_cnt[m]++;
						if (wait_cnt[m] >= WAIT_LIMIT) begin
							$display("timeout: master %0d got no ack or err within %0d cycles",
								m, WAIT_LIMIT);
							timeouts++;
						end
					end
				end else if (next_entry(g, m, pos[m]) >= 0) begin
					more = 1'b1;
				end
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		rstn = 1'b0;
		exp_err = '0;
		exp_we = '0;
		for (int m = 0; m < `WB_N_MASTERS; m++) begin
			m_req[m] = '0;
			exp_dat[m] = '0;
			exp_sel[m] = '0;
		end
		timeouts = 0;
		done_cnt = 0;
		n_ent = 0;
		rng_seed = 32'h93700946;
		void'($urandom(rng_seed));
		for (int i = 0; i < 256; i++) begin
			delay_tab[i] = 2'($urandom % 3);
		end

		// Every master writes one word into every slave
		add_entry(0, 0, 1, 32'h0000_0000, 32'h0100_A5A5, 4'hF, 0);
		add_entry(0, 0, 1, 32'h0000_1004, 32'h0101_5A5A, 4'hF, 0);
		add_entry(0, 0, 1, 32'h0001_0008, 32'h0102_3C3C, 4'hF, 0);
		add_entry(0, 1, 1, 32'h0000_1010, 32'h1101_C3C3, 4'hF, 0);
		add_entry(0, 1, 1, 32'h0001_0014, 32'h1102_0FF0, 4'hF, 0);
		add_entry(0, 1, 1, 32'h0000_0018, 32'h1100_F00F, 4'hF, 0);
		add_entry(0, 2, 1, 32'h0001_0020, 32'h2102_1234, 4'hF, 0);
		add_entry(0, 2, 1, 32'h0000_0024, 32'h2100_5678, 4'hF, 0);
		add_entry(0, 2, 1, 32'h0000_1028, 32'h2101_9ABC, 4'hF, 0);
		// Read back
		add_entry(1, 0, 0, 32'h0000_0000, 32'h0100_A5A5, 4'hF, 0);
		add_entry(1, 0, 0, 32'h0000_1004, 32'h0101_5A5A, 4'hF, 0);
		add_entry(1, 0, 0, 32'h0001_0008, 32'h0102_3C3C, 4'hF, 0);
		add_entry(1, 1, 0, 32'h0000_1010, 32'h1101_C3C3, 4'hF, 0);
		add_entry(1, 1, 0, 32'h0001_0014, 32'h1102_0FF0, 4'hF, 0);
		add_entry(1, 1, 0, 32'h0000_0018, 32'h1100_F00F, 4'hF, 0);
		add_entry(1, 2, 0, 32'h0001_0020, 32'h2102_1234, 4'hF, 0);
		add_entry(1, 2, 0, 32'h0000_0024, 32'h2100_5678, 4'hF, 0);
		add_entry(1, 2, 0, 32'h0000_1028, 32'h2101_9ABC, 4'hF, 0);
		// Unmapped addresses plus a partial write on the side
		add_entry(2, 0, 0, 32'h0000_2000, 32'h0000_0000, 4'hF, 1);
		add_entry(2, 1, 1, 32'h0002_0000, 32'h0BAD_0BAD, 4'hF, 1);
		add_entry(2, 2, 1, 32'h0000_0024, 32'h0000_BEEF, 4'h3, 0);
		// All three masters contend for slave 1
		add_entry(3, 0, 1, 32'h0000_1040, 32'hAAAA_0001, 4'hF, 0);
		add_entry(3, 1, 1, 32'h0000_1044, 32'hBBBB_0002, 4'hF, 0);
		add_entry(3, 2, 1, 32'h0000_1048, 32'hCCCC_0003, 4'hF, 0);
		add_entry(3, 0, 0, 32'h0000_1040, 32'hAAAA_0001, 4'hF, 0);
		add_entry(3, 1, 0, 32'h0000_1044, 32'hBBBB_0002, 4'hF, 0);
		add_entry(3, 2, 0, 32'h0000_1048, 32'hCCCC_0003, 4'hF, 0);
		// Masters 0 and 1 back to back on slave 2
		add_entry(4, 0, 0, 32'h0001_0008, 32'h0102_3C3C, 4'hF, 0);
		add_entry(4, 0, 0, 32'h0001_0008, 32'h0102_3C3C, 4'hF, 0);
		add_entry(4, 0, 0, 32'h0001_0008, 32'h0102_3C3C, 4'hF, 0);
		add_entry(4, 1, 0, 32'h0001_0014, 32'h1102_0FF0, 4'hF, 0);
		add_entry(4, 1, 0, 32'h0001_0014, 32'h1102_0FF0, 4'hF, 0);
		add_entry(4, 1, 0, 32'h0001_0014, 32'h1102_0FF0, 4'hF, 0);
		add_entry(4, 2, 0, 32'h0000_0024, 32'h2100_BEEF, 4'hF, 0);

		repeat (5) @(posedge clk);
		rstn <= 1'b1;
		for (int g = 0; g < 5; g++) begin
			if (timeouts == 0) begin
				run_group(g);
			end
		end
		repeat (3) @(posedge clk);
		$display("checks %0d, errors %0d, timeouts %0d, transfers %0d of %0d",
			chk_cnt, err_cnt, timeouts, done_cnt, n_ent);
		if (err_cnt == 0 && timeouts == 0 && done_cnt == n_ent) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: testbench/wb_xbar_checker.sv
// ##########################################################################
// Crossbar checker
// Watches both sides of the crossbar and compares responses, routing
// and arbitration order with the expected behavior
// ##########################################################################
`timescale 1ns/1ns
`include "wb_xbar_defines.svh"

module wb_xbar_checker (
	input logic clk,
	input logic rstn,
	input wb_xbar_pkg::wb_req_t m_req_i [`WB_N_MASTERS],
	input wb_xbar_pkg::wb_rsp_t m_rsp_i [`WB_N_MASTERS],
	input wb_xbar_pkg::wb_req_t s_req_i [`WB_N_SLAVES],
	input logic [`WB_N_MASTERS-1:0] exp_err_i,
	input logic [`WB_N_MASTERS-1:0] exp_we_i,
	input logic [`WB_DATA_WIDTH-1:0] exp_dat_i [`WB_N_MASTERS],
	input logic [`WB_DATA_WIDTH/8-1:0] exp_sel_i [`WB_N_MASTERS],
	output int err_cnt_o,
	output int chk_cnt_o
);
	import wb_xbar_pkg::*;

	int errors = 0;
	int checks = 0;
	// Completions of master o on a slave while master m kept waiting there
	int pass_cnt [`WB_N_MASTERS][`WB_N_MASTERS];

	assign err_cnt_o = errors;
	assign chk_cnt_o = checks;

	// Slave window that holds an address (3 when it hits none)
	function automatic int window_of(input logic [`WB_ADDR_WIDTH-1:0] adr);
		if (adr >= `WB_S0_BASE && adr <= `WB_S0_LIMIT) return 0;
		if (adr >= `WB_S1_BASE && adr <= `WB_S1_LIMIT) return 1;
		if (adr >= `WB_S2_BASE && adr <= `WB_S2_LIMIT) return 2;
		return 3;
	endfunction

	function automatic logic [`WB_DATA_WIDTH-1:0] byte_mask(
			input logic [`WB_DATA_WIDTH/8-1:0] sel);
		logic [`WB_DATA_WIDTH-1:0] mask;
		mask = '0;
		for (int b = 0; b < `WB_DATA_WIDTH / 8; b++) begin
			if (sel[b]) begin
				mask[8*b +: 8] = 8'hFF;
			end
		end
		return mask;
	endfunction

	function automatic logic strobing(input wb_req_t r);
		return r.cyc && r.stb;
	endfunction

	// Sample mid-cycle between two driving edges
	always @(negedge clk) begin : p_check
		logic hit;
		logic [`WB_DATA_WIDTH-1:0] mask;
		int k;
		if (!rstn) begin
			for (int m = 0; m < `WB_N_MASTERS; m++) begin
				for (int o = 0; o < `WB_N_MASTERS; o++) begin
					pass_cnt[m][o] = 0;
				end
			end
		end else begin
			// Each forwarded strobe lies in its slave window
			// and carries the address of a strobing master
			for (int s = 0; s < `WB_N_SLAVES; s++) begin
				if (strobing(s_req_i[s])) begin
					checks++;
					if (window_of(s_req_i[s].adr) != s) begin
						errors++;
						$display("error s_req_o[%0d].adr 0x%h lies outside the slave window",
							s, s_req_i[s].adr);
					end
					hit = 1'b0;
					for (int m = 0; m < `WB_N_MASTERS; m++) begin
						if (strobing(m_req_i[m]) && m_req_i[m].adr == s_req_i[s].adr) begin
							hit = 1'b1;
						end
					end
					if (!hit) begin
						errors++;
						$display("slave %0d was strobed at an address that no master strobes",
							s);
					end
				end
			end

			// Responses against the expected outcome
			for (int m = 0; m < `WB_N_MASTERS; m++) begin
				if (m_rsp_i[m].ack || m_rsp_i[m].err) begin
					checks++;
					mask = byte_mask(exp_sel_i[m]);
					if (!strobing(m_req_i[m])) begin
						errors++;
						$display("master %0d saw ack or err without its own strobe", m);
					end else if (m_rsp_i[m].err !== exp_err_i[m]) begin
						errors++;
						$display("error m_rsp_o[%0d].err got 0x%h expected 0x%h",
							m, m_rsp_i[m].err, exp_err_i[m]);
					end else if (m_rsp_i[m].err && m_rsp_i[m].dat_r !== '0) begin
						errors++;
						$display("error m_rsp_o[%0d].dat_r got 0x%h expected 0x%h",
							m, m_rsp_i[m].dat_r, {`WB_DATA_WIDTH{1'b0}});
					end else if (!exp_we_i[m] && !m_rsp_i[m].err &&
							(m_rsp_i[m].dat_r & mask) !== (exp_dat_i[m] & mask)) begin
						errors++;
						$display("error m_rsp_o[%0d].dat_r got 0x%h expected 0x%h",
							m, m_rsp_i[m].dat_r & mask, exp_dat_i[m] & mask);
					end
				end
			end

			// No master is served twice on a slave while another one waits there
			for (int o = 0; o < `WB_N_MASTERS; o++) begin
				if (m_rsp_i[o].ack) begin
					k = window_of(m_req_i[o].adr);
					for (int m = 0; m < `WB_N_MASTERS; m++) begin
						if (m != o && strobing(m_req_i[m]) && !m_rsp_i[m].ack &&
								!m_rsp_i[m].err && window_of(m_req_i[m].adr) == k) begin
							pass_cnt[m][o]++;
							if (pass_cnt[m][o] > 1) begin
								errors++;
								$display({"master %0d was served twice on slave %0d",
									" while master %0d waited"}, o, k, m);
							end
						end
					end
				end
			end
			// Waiting ends with the master's own response or a dropped strobe
			for (int m = 0; m < `WB_N_MASTERS; m++) begin
				if (!strobing(m_req_i[m]) || m_rsp_i[m].ack || m_rsp_i[m].err) begin
					for (int o = 0; o < `WB_N_MASTERS; o++) begin
						pass_cnt[m][o] = 0;
					end
				end
			end
		end
	end

endmodule
